/* design/exe_pkg.sv */
package exe_pkg;

    localparam int xlen        = 32;
    localparam int mul_width   = xlen + 1;   // one extra bit for sign extension
    localparam int iid_width   = 8;
    localparam int shamt_width = $clog2(xlen);

    localparam int mdu_cnt_width = $clog2(mul_width);
    localparam logic [mdu_cnt_width-1:0] mdu_last_step = mdu_cnt_width'(mul_width - 1);

    typedef enum logic [4:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_copy2,   // lui
        alu_mul,
        alu_mulh,
        alu_mulhsu,
        alu_mulhu,
        alu_div,
        alu_divu,
        alu_rem,
        alu_remu
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu
    } br_op_e;

    typedef enum logic [1:0] {
        mdu_idle,
        mdu_busy,
        mdu_done    // result held for saved id
    } mdu_state_e;

endpackage

/* design/exe_alu.sv */
`timescale 1ns/1ps

module exe_alu (
    input  exe_pkg::alu_op_e            i_op,
    input  exe_pkg::br_op_e             i_br,
    input  logic [exe_pkg::xlen-1:0]    i_op1,
    input  logic [exe_pkg::xlen-1:0]    i_op2,
    output logic [exe_pkg::xlen-1:0]    o_result,
    output logic                        o_branch_take
);

    logic [exe_pkg::shamt_width-1:0] shamt;
    logic                            op_eq;
    logic                            op_lt;
    logic                            op_ltu;

    assign shamt  = i_op2[exe_pkg::shamt_width-1:0];
    assign op_eq  = (i_op1 == i_op2);
    assign op_lt  = ($signed(i_op1) < $signed(i_op2));
    assign op_ltu = (i_op1 < i_op2);

    always_comb begin
        case (i_op)
            exe_pkg::alu_add:   o_result = i_op1 + i_op2;
            exe_pkg::alu_sub:   o_result = i_op1 - i_op2;
            exe_pkg::alu_sll:   o_result = i_op1 << shamt;
            exe_pkg::alu_slt:   o_result = {{(exe_pkg::xlen-1){1'b0}}, op_lt};
            exe_pkg::alu_sltu:  o_result = {{(exe_pkg::xlen-1){1'b0}}, op_ltu};
            exe_pkg::alu_xor:   o_result = i_op1 ^ i_op2;
            exe_pkg::alu_srl:   o_result = i_op1 >> shamt;
            exe_pkg::alu_sra:   o_result = $unsigned($signed(i_op1) >>> shamt);
            exe_pkg::alu_or:    o_result = i_op1 | i_op2;
            exe_pkg::alu_and:   o_result = i_op1 & i_op2;
            exe_pkg::alu_copy2: o_result = i_op2;
            default:            o_result = '0;   // mul/div handled by the stage
        endcase
    end

    always_comb begin
        case (i_br)
            exe_pkg::br_beq:  o_branch_take = op_eq;
            exe_pkg::br_bne:  o_branch_take = !op_eq;
            exe_pkg::br_blt:  o_branch_take = op_lt;
            exe_pkg::br_bge:  o_branch_take = !op_lt;
            exe_pkg::br_bltu: o_branch_take = op_ltu;
            exe_pkg::br_bgeu: o_branch_take = !op_ltu;
            default:          o_branch_take = 1'b0;
        endcase
    end

endmodule

/* design/exe_mult.sv */
`timescale 1ns/1ps

module exe_mult (
    input  logic                                clk,
    input  logic                                i_arst_n,
    input  logic                                i_start,
    input  logic [exe_pkg::mul_width-1:0]       i_op_a,
    input  logic [exe_pkg::mul_width-1:0]       i_op_b,
    output logic                                o_ready,
    output logic                                o_done,
    output logic [2*exe_pkg::mul_width-1:0]     o_product
);

    logic                                busy;
    logic                                load;
    logic                                last_step;
    logic [exe_pkg::mdu_cnt_width-1:0]   step_cnt;
    logic [exe_pkg::mul_width-1:0]       mcand;
    logic [exe_pkg::mul_width:0]         acc;      // upper half, one guard bit
    logic [exe_pkg::mul_width-1:0]       mplier;   // lower half, shifts out multiplier
    logic [exe_pkg::mul_width-1:0]       cur_a;
    logic [exe_pkg::mul_width:0]         cur_acc;
    logic [exe_pkg::mul_width-1:0]       cur_mq;
    logic [exe_pkg::mul_width:0]         addend;
    logic [exe_pkg::mul_width:0]         sum;

    assign load      = i_start && !busy;
    assign last_step = busy && (step_cnt == exe_pkg::mdu_last_step);

    // first step runs on the start edge
    assign cur_a   = load ? i_op_a : mcand;
    assign cur_acc = load ? '0 : acc;
    assign cur_mq  = load ? i_op_b : mplier;

    assign addend = cur_mq[0] ? {cur_a[exe_pkg::mul_width-1], cur_a} : '0;
    assign sum    = last_step ? cur_acc - addend : cur_acc + addend;   // sign bit has weight -2^32

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done <= last_step;
            if (load) begin
                busy     <= 1'b1;
                step_cnt <= exe_pkg::mdu_cnt_width'(1);
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (last_step)
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load)
            mcand <= i_op_a;
        if (load || busy) begin
            acc    <= {sum[exe_pkg::mul_width], sum[exe_pkg::mul_width:1]};
            mplier <= {sum[0], cur_mq[exe_pkg::mul_width-1:1]};
        end
    end

    assign o_ready   = !busy;
    assign o_product = {acc[exe_pkg::mul_width-1:0], mplier};

endmodule

/* design/exe_div.sv */
`timescale 1ns/1ps

module exe_div (
    input  logic                            clk,
    input  logic                            i_arst_n,
    input  logic                            i_start,
    input  logic [exe_pkg::mul_width-1:0]   i_dividend,
    input  logic [exe_pkg::mul_width-1:0]   i_divisor,
    output logic                            o_ready,
    output logic                            o_done,
    output logic [exe_pkg::mul_width-1:0]   o_quotient,
    output logic [exe_pkg::mul_width-1:0]   o_remainder
);

    logic                                busy;
    logic                                load;
    logic                                last_step;
    logic [exe_pkg::mdu_cnt_width-1:0]   step_cnt;
    logic                                div_zero;
    logic                                q_neg;
    logic                                r_neg;
    logic [exe_pkg::mul_width-1:0]       a_mag;
    logic [exe_pkg::mul_width-1:0]       b_mag;
    logic [exe_pkg::mul_width-1:0]       dmag;
    logic [exe_pkg::mul_width-1:0]       rem;
    logic [exe_pkg::mul_width-1:0]       quo;
    logic [exe_pkg::mul_width-1:0]       cur_dmag;
    logic [exe_pkg::mul_width-1:0]       cur_rem;
    logic [exe_pkg::mul_width-1:0]       cur_quo;
    logic [exe_pkg::mul_width:0]         shifted;
    logic [exe_pkg::mul_width+1:0]       diff;
    logic                                fits;

    assign load      = i_start && !busy;
    assign last_step = busy && (step_cnt == exe_pkg::mdu_last_step);

    assign a_mag = i_dividend[exe_pkg::mul_width-1] ? -i_dividend : i_dividend;
    assign b_mag = i_divisor[exe_pkg::mul_width-1] ? -i_divisor : i_divisor;

    assign cur_dmag = load ? b_mag : dmag;
    assign cur_rem  = load ? '0 : rem;
    assign cur_quo  = load ? a_mag : quo;   // dividend bits shift out the top

    assign shifted = {cur_rem, cur_quo[exe_pkg::mul_width-1]};
    assign diff    = {1'b0, shifted} - {2'b00, cur_dmag};
    assign fits    = !diff[exe_pkg::mul_width+1];   // no borrow

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done <= last_step;
            if (load) begin
                busy     <= 1'b1;
                step_cnt <= exe_pkg::mdu_cnt_width'(1);
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (last_step)
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dmag     <= b_mag;
            div_zero <= (i_divisor == '0);
            q_neg    <= i_dividend[exe_pkg::mul_width-1] ^ i_divisor[exe_pkg::mul_width-1];
            r_neg    <= i_dividend[exe_pkg::mul_width-1];
        end
        if (load || busy) begin
            rem <= fits ? diff[exe_pkg::mul_width-1:0] : shifted[exe_pkg::mul_width-1:0];
            quo <= {cur_quo[exe_pkg::mul_width-2:0], fits};
        end
    end

    // zero divisor leaves the dividend magnitude in rem
    assign o_ready     = !busy;
    assign o_quotient  = div_zero ? '1 : (q_neg ? -quo : quo);
    assign o_remainder = r_neg ? -rem : rem;

endmodule

/* design/exe_stage.sv */
`timescale 1ns/1ps

module exe_stage (
    input  logic                            clk,
    input  logic                            i_arst_n,
    input  logic                            i_valid,
    input  logic [exe_pkg::xlen-1:0]        i_pc,
    input  logic [exe_pkg::iid_width-1:0]   i_inst_id,
    input  exe_pkg::alu_op_e                i_alu_op,
    input  exe_pkg::br_op_e                 i_br_op,
    input  logic                            i_jmp_pc,
    input  logic                            i_jmp_reg,
    input  logic [exe_pkg::xlen-1:0]        i_imm_b,
    input  logic [exe_pkg::xlen-1:0]        i_imm_j,
    input  logic [exe_pkg::xlen-1:0]        i_op1,
    input  logic [exe_pkg::xlen-1:0]        i_op2,
    output logic                            o_valid,
    output logic [exe_pkg::iid_width-1:0]   o_inst_id,
    output logic [exe_pkg::xlen-1:0]        o_result,
    output logic                            o_stall,
    output logic                            o_branch_taken,
    output logic [exe_pkg::xlen-1:0]        o_branch_target
);

    exe_pkg::mdu_state_e                    state;
    logic [exe_pkg::iid_width-1:0]          saved_id;
    logic [exe_pkg::xlen-1:0]               saved_result;
    logic [exe_pkg::xlen-1:0]               mdu_slice;
    logic [exe_pkg::xlen-1:0]               alu_result;
    logic                                   alu_branch_take;
    logic                                   is_mul;
    logic                                   is_div;
    logic                                   is_mdu;
    logic                                   held;
    logic                                   may_start;
    logic                                   unit_done;
    logic                                   mul_a_signed;
    logic                                   mul_b_signed;
    logic                                   div_signed;
    logic                                   mul_start;
    logic                                   mul_ready;
    logic                                   mul_done;
    logic [exe_pkg::mul_width-1:0]          mul_a;
    logic [exe_pkg::mul_width-1:0]          mul_b;
    logic [2*exe_pkg::mul_width-1:0]        product;
    logic                                   div_start;
    logic                                   div_ready;
    logic                                   div_done;
    logic [exe_pkg::mul_width-1:0]          div_a;
    logic [exe_pkg::mul_width-1:0]          div_b;
    logic [exe_pkg::mul_width-1:0]          quotient;
    logic [exe_pkg::mul_width-1:0]          remainder;

    exe_alu u_alu (
        .i_op          (i_alu_op),
        .i_br          (i_br_op),
        .i_op1         (i_op1),
        .i_op2         (i_op2),
        .o_result      (alu_result),
        .o_branch_take (alu_branch_take)
    );

    assign is_mul = i_alu_op inside {exe_pkg::alu_mul, exe_pkg::alu_mulh,
                                     exe_pkg::alu_mulhsu, exe_pkg::alu_mulhu};
    assign is_div = i_alu_op inside {exe_pkg::alu_div, exe_pkg::alu_divu,
                                     exe_pkg::alu_rem, exe_pkg::alu_remu};
    assign is_mdu = is_mul || is_div;

    // same instruction re-presented after its result was saved
    assign held      = (state == exe_pkg::mdu_done) && (saved_id == i_inst_id);
    assign may_start = i_valid && is_mdu && (state != exe_pkg::mdu_busy) && !held;

    assign mul_a_signed = (i_alu_op != exe_pkg::alu_mulhu);
    assign mul_b_signed = (i_alu_op == exe_pkg::alu_mul) || (i_alu_op == exe_pkg::alu_mulh);
    assign div_signed   = (i_alu_op == exe_pkg::alu_div) || (i_alu_op == exe_pkg::alu_rem);

    assign mul_a = {mul_a_signed && i_op1[exe_pkg::xlen-1], i_op1};
    assign mul_b = {mul_b_signed && i_op2[exe_pkg::xlen-1], i_op2};
    assign div_a = {div_signed && i_op1[exe_pkg::xlen-1], i_op1};
    assign div_b = {div_signed && i_op2[exe_pkg::xlen-1], i_op2};

    assign mul_start = may_start && is_mul && mul_ready;
    assign div_start = may_start && is_div && div_ready;
    assign unit_done = is_mul ? mul_done : div_done;

    exe_mult u_mult (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_start   (mul_start),
        .i_op_a    (mul_a),
        .i_op_b    (mul_b),
        .o_ready   (mul_ready),
        .o_done    (mul_done),
        .o_product (product)
    );

    exe_div u_div (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_start     (div_start),
        .i_dividend  (div_a),
        .i_divisor   (div_b),
        .o_ready     (div_ready),
        .o_done      (div_done),
        .o_quotient  (quotient),
        .o_remainder (remainder)
    );

    always_comb begin
        case (i_alu_op)
            exe_pkg::alu_mul:  mdu_slice = product[exe_pkg::xlen-1:0];
            exe_pkg::alu_mulh,
            exe_pkg::alu_mulhsu,
            exe_pkg::alu_mulhu: mdu_slice = product[2*exe_pkg::xlen-1:exe_pkg::xlen];
            exe_pkg::alu_div,
            exe_pkg::alu_divu: mdu_slice = quotient[exe_pkg::xlen-1:0];
            default:           mdu_slice = remainder[exe_pkg::xlen-1:0];
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state    <= exe_pkg::mdu_idle;
            saved_id <= '0;
        end else if (!i_valid || !is_mdu) begin
            state <= exe_pkg::mdu_idle;   // bubble or single-cycle op
        end else begin
            case (state)
                exe_pkg::mdu_idle,
                exe_pkg::mdu_done: begin
                    if (mul_start || div_start)
                        state <= exe_pkg::mdu_busy;
                end
                exe_pkg::mdu_busy: begin
                    if (unit_done) begin
                        state    <= exe_pkg::mdu_done;
                        saved_id <= i_inst_id;
                    end
                end
                default: state <= exe_pkg::mdu_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == exe_pkg::mdu_busy && unit_done)
            saved_result <= mdu_slice;
    end

    assign o_stall   = i_valid && is_mdu && !held;
    assign o_valid   = i_valid && !o_stall;
    assign o_inst_id = i_inst_id;
    assign o_result  = is_mdu ? saved_result : alu_result;

    assign o_branch_taken  = i_valid && (i_jmp_pc || i_jmp_reg || alu_branch_take);
    assign o_branch_target = i_jmp_pc  ? i_pc + i_imm_j :
                             i_jmp_reg ? i_op1 + i_op2 :
                                         i_pc + i_imm_b;

endmodule

/* verif/exe_stage_asserts.sv */
`timescale 1ns/1ps

module exe_stage_asserts (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic                    i_valid,    // stage o_valid
    input  logic                    i_stall,    // stage o_stall
    input  exe_pkg::mdu_state_e     i_state
);

    int fail_cnt = 0;

    // result goes out in the cycle the stall drops
    stall_release: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        $fell(i_stall) |-> i_valid && (i_state == exe_pkg::mdu_done)
    ) else begin
        $error("o_stall fell without the multi-cycle result going out");
        fail_cnt++;
    end

    // 34 cycles nominal for mul/div
    stall_bounded: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        $rose(i_stall) |-> ##[1:40] !i_stall
    ) else begin
        $error("o_stall held longer than 40 cycles");
        fail_cnt++;
    end

    idle_after_reset: assert property (
        @(posedge clk)
        $rose(i_arst_n) |-> (i_state == exe_pkg::mdu_idle)
    ) else begin
        $error("multi-cycle control not idle after reset");
        fail_cnt++;
    end

endmodule

bind exe_stage exe_stage_asserts u_exe_stage_asserts (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_valid  (o_valid),
    .i_stall  (o_stall),
    .i_state  (state)
);

/* verif/exe_stage_tb.sv */
`timescale 1ns/1ps

module exe_stage_tb;

    logic                           clk;
    logic                           arst_n;
    logic                           valid;
    logic [exe_pkg::xlen-1:0]       pc;
    logic [exe_pkg::iid_width-1:0]  inst_id;
    exe_pkg::alu_op_e               alu_op;
    exe_pkg::br_op_e                br_op;
    logic                           jmp_pc;
    logic                           jmp_reg;
    logic [exe_pkg::xlen-1:0]       imm_b;
    logic [exe_pkg::xlen-1:0]       imm_j;
    logic [exe_pkg::xlen-1:0]       op1;
    logic [exe_pkg::xlen-1:0]       op2;
    logic                           out_valid;
    logic [exe_pkg::iid_width-1:0]  out_id;
    logic [exe_pkg::xlen-1:0]       result;
    logic                           stall;
    logic                           br_taken;
    logic [exe_pkg::xlen-1:0]       br_target;

    logic [31:0]                    lfsr;
    logic [31:0]                    ra;
    logic [31:0]                    rb;
    exe_pkg::alu_op_e               rop;
    exe_pkg::br_op_e                rbr;
    logic                           timed_out;
    int                             checks;
    int                             errors;
    int                             mark_checks;
    int                             mark_errors;
    int                             i;
    int                             j;
    int                             k;
    int                             r;

    exe_stage uut (
        .clk             (clk),
        .i_arst_n        (arst_n),
        .i_valid         (valid),
        .i_pc            (pc),
        .i_inst_id       (inst_id),
        .i_alu_op        (alu_op),
        .i_br_op         (br_op),
        .i_jmp_pc        (jmp_pc),
        .i_jmp_reg       (jmp_reg),
        .i_imm_b         (imm_b),
        .i_imm_j         (imm_j),
        .i_op1           (op1),
        .i_op2           (op2),
        .o_valid         (out_valid),
        .o_inst_id       (out_id),
        .o_result        (result),
        .o_stall         (stall),
        .o_branch_taken  (br_taken),
        .o_branch_target (br_target)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h8020_0003;   // x^32+x^22+x^2+x+1
        return n;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic is_multi(input exe_pkg::alu_op_e op);
        return int'(op) >= int'(exe_pkg::alu_mul);
    endfunction

    function automatic logic [31:0] model_result(input exe_pkg::alu_op_e op,
                                                 input logic [31:0] a,
                                                 input logic [31:0] b);
        longint      sa;
        longint      sb;
        longint      q;
        logic [63:0] p;
        logic [63:0] ext;
        logic [31:0] res;
        sa  = longint'($signed(a));
        sb  = longint'($signed(b));
        ext = {{32{a[31]}}, a};
        res = '0;
        case (op)
            exe_pkg::alu_add:    res = a + b;
            exe_pkg::alu_sub:    res = a - b;
            exe_pkg::alu_sll:    res = a << b[4:0];
            exe_pkg::alu_slt:    res = (sa < sb) ? 32'd1 : 32'd0;
            exe_pkg::alu_sltu:   res = (a < b) ? 32'd1 : 32'd0;
            exe_pkg::alu_xor:    res = a ^ b;
            exe_pkg::alu_srl:    res = a >> b[4:0];
            exe_pkg::alu_sra: begin
                p   = ext >> b[4:0];
                res = p[31:0];
            end
            exe_pkg::alu_or:     res = a | b;
            exe_pkg::alu_and:    res = a & b;
            exe_pkg::alu_copy2:  res = b;
            exe_pkg::alu_mul: begin
                p   = sa * sb;
                res = p[31:0];
            end
            exe_pkg::alu_mulh: begin
                p   = sa * sb;
                res = p[63:32];
            end
            exe_pkg::alu_mulhsu: begin
                p   = sa * longint'({32'b0, b});
                res = p[63:32];
            end
            exe_pkg::alu_mulhu: begin
                p   = {32'b0, a} * {32'b0, b};
                res = p[63:32];
            end
            exe_pkg::alu_div: begin
                q   = (b == 0) ? -1 : (a == 32'h8000_0000 && b == '1) ? sa : sa / sb;
                res = q[31:0];
            end
            exe_pkg::alu_divu:   res = (b == 0) ? '1 : a / b;
            exe_pkg::alu_rem: begin
                q   = (b == 0) ? sa : (a == 32'h8000_0000 && b == '1) ? 0 : sa % sb;
                res = q[31:0];
            end
            exe_pkg::alu_remu:   res = (b == 0) ? a : a % b;
            default:             res = '0;
        endcase
        return res;
    endfunction

    function automatic logic model_taken(input exe_pkg::br_op_e br, input logic jp,
                                         input logic jr, input logic [31:0] a,
                                         input logic [31:0] b);
        logic cond;
        case (br)
            exe_pkg::br_beq:  cond = (a == b);
            exe_pkg::br_bne:  cond = (a != b);
            exe_pkg::br_blt:  cond = ($signed(a) < $signed(b));
            exe_pkg::br_bge:  cond = ($signed(a) >= $signed(b));
            exe_pkg::br_bltu: cond = (a < b);
            exe_pkg::br_bgeu: cond = (a >= b);
            default:          cond = 1'b0;
        endcase
        return jp || jr || cond;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            $display("** Error at %0t: %s is %h, expected %h (id %0d)",
                     $time, what, got, exp, inst_id);
            errors++;
        end
    endtask

    task automatic drive(input exe_pkg::alu_op_e op, input exe_pkg::br_op_e br,
                         input logic jp, input logic jr, input logic [31:0] a,
                         input logic [31:0] b);
        @(posedge clk);
        valid   <= 1'b1;
        inst_id <= inst_id + 1'b1;   // fresh id for every instruction
        alu_op  <= op;
        br_op   <= br;
        jmp_pc  <= jp;
        jmp_reg <= jr;
        op1     <= a;
        op2     <= b;
        pc      <= rand_bits(32);
        imm_b   <= rand_bits(32);
        imm_j   <= rand_bits(32);
    endtask

    task automatic check_outputs;
        int          cycles;
        logic [31:0] target;
        @(negedge clk);
        cycles = 0;
        if (is_multi(alu_op)) begin
            check_value("o_stall on arrival", stall, 1);
            while (stall && cycles < 60) begin
                @(negedge clk);
                cycles++;
            end
        end else begin
            check_value("o_stall", stall, 0);
        end
        if (is_multi(alu_op) && stall) begin
            $display("timeout: o_stall still high 60 cycles after id %0d arrived",
                     inst_id);
            errors++;
            timed_out = 1'b1;
        end else begin
            target = jmp_pc ? pc + imm_j : (jmp_reg ? op1 + op2 : pc + imm_b);
            check_value("o_valid", out_valid, 1);
            check_value("o_inst_id", out_id, inst_id);
            check_value("o_result", result, model_result(alu_op, op1, op2));
            check_value("o_branch_taken", br_taken,
                        model_taken(br_op, jmp_pc, jmp_reg, op1, op2));
            check_value("o_branch_target", br_target, target);
        end
    endtask

    task automatic issue(input exe_pkg::alu_op_e op, input exe_pkg::br_op_e br,
                         input logic jp, input logic jr, input logic [31:0] a,
                         input logic [31:0] b);
        if (!timed_out) begin
            drive(op, br, jp, jr, a, b);
            check_outputs();
        end
    endtask

    task automatic bubble;
        @(posedge clk);
        valid <= 1'b0;
        @(negedge clk);
        check_value("o_valid on bubble", out_valid, 0);
        check_value("o_stall on bubble", stall, 0);
    endtask

    task automatic apply_reset;
        @(posedge clk);
        arst_n <= 1'b0;
        valid  <= 1'b0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic report_test(input string name);
        $display("%-10s %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        valid       = 1'b0;
        pc          = '0;
        inst_id     = '0;
        alu_op      = exe_pkg::alu_add;
        br_op       = exe_pkg::br_none;
        jmp_pc      = 1'b0;
        jmp_reg     = 1'b0;
        imm_b       = '0;
        imm_j       = '0;
        op1         = '0;
        op2         = '0;
        lfsr        = 32'd82294;
        timed_out   = 1'b0;
        checks      = 0;
        errors      = 0;
        mark_checks = 0;
        mark_errors = 0;
        apply_reset();

        for (i = 0; i < 200; i++) begin
            rop = exe_pkg::alu_op_e'(rand_bits(4) % 11);
            ra  = rand_bits(32);
            rb  = rand_bits(32);
            issue(rop, exe_pkg::br_none, 1'b0, 1'b0, ra, rb);
        end
        report_test("alu");

        for (i = 0; i < 7; i++) begin
            for (k = 0; k < 3; k++) begin
                for (j = 0; j < 4; j++) begin
                    ra = rand_bits(32);
                    rb = rand_bits(32);
                    if (j == 1)
                        rb = ra;
                    else if (j == 3)
                        rb = ra ^ 32'h8000_0000;   // signed and unsigned disagree
                    issue(exe_pkg::alu_sub, exe_pkg::br_op_e'(i), k == 1, k == 2, ra, rb);
                end
            end
        end
        report_test("branch");

        for (i = 0; i < 60; i++) begin
            ra  = (i % 8 == 0) ? 32'h8000_0000 : rand_bits(32);
            rb  = (i % 8 == 1) ? 32'hffff_ffff : rand_bits(32);
            rop = exe_pkg::alu_op_e'(int'(exe_pkg::alu_mul) + i % 4);
            issue(rop, exe_pkg::br_none, 1'b0, 1'b0, ra, rb);
        end
        report_test("multiply");

        for (i = 0; i < 60; i++) begin
            ra = rand_bits(32);
            rb = rand_bits(32);
            if (i < 4) begin
                rb = '0;
            end else if (i < 8) begin
                ra = 32'h8000_0000;
                rb = '1;
            end else if (i % 3 == 0) begin
                rb = rand_bits(6);
            end
            rop = exe_pkg::alu_op_e'(int'(exe_pkg::alu_div) + i % 4);
            issue(rop, exe_pkg::br_none, 1'b0, 1'b0, ra, rb);
        end
        report_test("divide");

        for (i = 0; i < 40; i++) begin
            r  = rand_bits(3);
            ra = rand_bits(32);
            rb = rand_bits(32);
            case (r)
                5:       rop = exe_pkg::alu_op_e'(int'(exe_pkg::alu_mul) + rand_bits(2));
                6:       rop = exe_pkg::alu_op_e'(int'(exe_pkg::alu_div) + rand_bits(2));
                default: rop = exe_pkg::alu_op_e'(rand_bits(4) % 11);
            endcase
            rbr = (r == 7) ? exe_pkg::br_op_e'(rand_bits(3) % 7) : exe_pkg::br_none;
            if (r < 2)
                bubble();
            else
                issue(rop, rbr, (r == 7) && ra[0], 1'b0, ra, rb);
        end
        ra = rand_bits(32);
        rb = rand_bits(32);
        drive(exe_pkg::alu_mulhu, exe_pkg::br_none, 1'b0, 1'b0, ra, rb);
        repeat (12) @(posedge clk);   // multiplier is busy here
        apply_reset();
        @(negedge clk);
        check_value("o_stall after reset", stall, 0);
        check_value("o_valid after reset", out_valid, 0);
        ra = rand_bits(32);
        rb = rand_bits(32);
        issue(exe_pkg::alu_rem, exe_pkg::br_none, 1'b0, 1'b0, ra, rb);
        issue(exe_pkg::alu_mulh, exe_pkg::br_none, 1'b0, 1'b0, rb, ra);
        issue(exe_pkg::alu_xor, exe_pkg::br_bne, 1'b0, 1'b0, ra, rb);
        report_test("mixed");

        errors += uut.u_exe_stage_asserts.fail_cnt;   // bound checker failures
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* flist.f */
design/exe_pkg.sv
design/exe_alu.sv
design/exe_mult.sv
design/exe_div.sv
design/exe_stage.sv
verif/exe_stage_asserts.sv
verif/exe_stage_tb.sv
